//--- src.f
ig_geom_pkg.sv
ig_flow_pkg.sv
pixel_fetch.sv
pixel_fifo.sv
grad_engine.sv
grad_writer.sv
ig.sv
tb_ig.sv

//--- tb_ig.sv
`timescale 1ns/1ps

module tb_ig
    import ig_geom_pkg::*;
    import ig_flow_pkg::*;
();

    localparam int         TIMEOUT_CYCLES = 3 * PIX_COUNT * 4;
    localparam int         TAIL_CYCLES    = 32;
    localparam grad_word_t SENTINEL       = '1;

    logic       clk;
    logic       reset;
    pixel_t     img_di;
    logic       grad_wait;
    logic       done;
    logic       img_rd;
    pix_addr_t  img_addr;
    logic       grad_wr;
    pix_addr_t  grad_addr;
    grad_word_t grad_do;

    // memory models and the pass 1 image copy
    pixel_t     img_mem    [PIX_COUNT];
    pixel_t     img_saved  [PIX_COUNT];
    grad_word_t grad_mem   [PIX_COUNT];
    int         wr_cnt     [PIX_COUNT];

    logic [31:0] img_state  = 32'hd818;
    logic [31:0] wait_state = 32'hd818;
    logic        rand_wait  = 1'b0;
    logic        check_busy = 1'b0;

    // bus model state
    logic      rd_pend = 1'b0;
    pix_addr_t rd_pend_addr;
    logic      nxt_wait;
    logic      done_seen   = 1'b0;
    int        rd_total    = 0;
    int        wr_total    = 0;
    int        cycle_count = 0;

    ig dut_i (
        .clk       (clk),
        .reset     (reset),
        .img_di    (img_di),
        .grad_wait (grad_wait),
        .done      (done),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // forward differences to the right and lower neighbours
    function automatic grad_word_t ref_word(input int x, input int y);
        int         p;
        int         pr;
        int         pd;
        logic [9:0] gx;
        logic [9:0] gy;
        p  = img_mem[y * IMG_W + x];
        pr = img_mem[y * IMG_W + x + 1];
        pd = img_mem[(y + 1) * IMG_W + x];
        gx = 10'(pr - p);
        gy = 10'(pd - p);
        return {gx, gy};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_with_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", msg);
    endtask

    task automatic load_random_image();
        for (int a = 0; a < PIX_COUNT; a++) begin
            img_state    = lcg_next(img_state);
            img_mem[a]   = img_state[23:16];
            img_saved[a] = img_state[23:16];
        end
    endtask

    // 255 on odd columns and odd rows and 0 elsewhere
    task automatic load_stripe_image();
        for (int a = 0; a < PIX_COUNT; a++) begin
            img_mem[a] = ((a & 1) | ((a >> 8) & 1)) ? 8'hff : 8'h00;
        end
    endtask

    task automatic restore_image();
        for (int a = 0; a < PIX_COUNT; a++) begin
            img_mem[a] = img_saved[a];
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset <= 1'b1;
        repeat (4) @(negedge clk);
        reset <= 1'b0;
    endtask

    task automatic run_pass(input logic wait_on);
        for (int a = 0; a < PIX_COUNT; a++) begin
            grad_mem[a] = SENTINEL;
            wr_cnt[a]   = 0;
        end
        rand_wait = wait_on;
        apply_reset();
        while (!done) begin
            @(negedge clk);
        end
        // quiet tail that done has to hold through
        repeat (TAIL_CYCLES) @(negedge clk);
        check_busy = 1'b1;
        wait (!check_busy);
    endtask

    // --------------------
    // memory models and bus checks
    // --------------------
    always @(negedge clk) begin
        if (reset) begin
            rd_pend   = 1'b0;
            rd_total  = 0;
            wr_total  = 0;
            done_seen = 1'b0;
            grad_wait <= 1'b0;
        end else begin
            // registered read with data valid for the edge after next
            if (rd_pend) begin
                img_di <= img_mem[rd_pend_addr];
            end
            rd_pend      = img_rd;
            rd_pend_addr = img_addr;
            if (img_rd) begin
                check_value("img_addr", img_addr, rd_total);
                rd_total++;
            end

            nxt_wait = 1'b0;
            if (rand_wait) begin
                wait_state = lcg_next(wait_state);
                nxt_wait   = wait_state[20];
            end
            grad_wait <= nxt_wait;

            // write lands on the coming rising edge
            if (grad_wr && !nxt_wait) begin
                grad_mem[grad_addr] = grad_do;
                wr_cnt[grad_addr]++;
                wr_total++;
            end

            if (done_seen && !done) begin
                stop_with_error("done fell before the next reset");
            end
            if (done && (img_rd || grad_wr)) begin
                stop_with_error("memory access after done");
            end
            done_seen = done_seen || done;
        end
    end

    // result walk over the whole gradient memory
    initial begin
        int x;
        int y;
        forever begin
            wait (check_busy);
            for (int a = 0; a < PIX_COUNT; a++) begin
                x = a % IMG_W;
                y = a / IMG_W;
                if (x < IMG_W - 1 && y < IMG_H - 1) begin
                    check_value($sformatf("grad_mem[%04h]", a), grad_mem[a], ref_word(x, y));
                    check_value($sformatf("write count[%04h]", a), wr_cnt[a], 1);
                end else begin
                    check_value($sformatf("unwritten grad_mem[%04h]", a), grad_mem[a],
                                SENTINEL);
                end
            end
            check_value("img_rd count", rd_total, PIX_COUNT);
            check_value("grad_wr count", wr_total, OUT_COUNT);
            check_busy = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_error("timeout, done never came within the cycle limit");
        end
    end

    // --------------------
    // passes
    // --------------------
    initial begin
        reset     = 1'b1;
        img_di    = '0;
        grad_wait = 1'b0;

        // random image on a memory that never stalls
        load_random_image();
        run_pass(1'b0);

        // stripes give full scale differences of both signs
        load_stripe_image();
        run_pass(1'b0);

        // same random image again with a stalling gradient memory
        restore_image();
        run_pass(1'b1);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- ig.sv
`timescale 1ns/1ps

module ig
    import ig_geom_pkg::*;
    import ig_flow_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  pixel_t     img_di,
    input  logic       grad_wait,
    output logic       done,
    output logic       img_rd,
    output pix_addr_t  img_addr,
    output logic       grad_wr,
    output pix_addr_t  grad_addr,
    output grad_word_t grad_do
);

    // credit loop
    logic credit_return;

    // FIFO to engine
    logic   pix_valid;
    logic   pix_pop;
    pixel_t pix_data;

    // engine to writer
    logic       res_valid;
    logic       res_ready;
    grad_word_t res_data;
    pix_addr_t  res_addr;

    // --------------------
    // image side
    // --------------------
    pixel_fetch fetch_i (
        .clk           (clk),
        .reset         (reset),
        .credit_return (credit_return),
        .img_rd        (img_rd),
        .img_addr      (img_addr)
    );

    pixel_fifo fifo_i (
        .clk           (clk),
        .reset         (reset),
        .img_rd        (img_rd),
        .img_di        (img_di),
        .pix_pop       (pix_pop),
        .pix_valid     (pix_valid),
        .pix_data      (pix_data),
        .credit_return (credit_return)
    );

    // --------------------
    // gradient side
    // --------------------
    grad_engine engine_i (
        .clk       (clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .res_ready (res_ready),
        .pix_pop   (pix_pop),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_addr  (res_addr)
    );

    grad_writer writer_i (
        .clk       (clk),
        .reset     (reset),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_addr  (res_addr),
        .grad_wait (grad_wait),
        .res_ready (res_ready),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

endmodule

//--- grad_writer.sv
`timescale 1ns/1ps

module grad_writer
    import ig_geom_pkg::*;
    import ig_flow_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       res_valid,
    input  grad_word_t res_data,
    input  pix_addr_t  res_addr,
    input  logic       grad_wait,
    output logic       res_ready,
    output logic       grad_wr,
    output pix_addr_t  grad_addr,
    output grad_word_t grad_do,
    output logic       done
);

    logic accept;
    logic load;

    // number of writes the memory has taken so far
    logic [$clog2(OUT_COUNT+1)-1:0] wr_count;

    // memory takes the held word on an edge without wait
    assign accept = grad_wr && !grad_wait;

    // slot is free, or frees up on this edge
    assign res_ready = !grad_wr || accept;
    assign load      = res_valid && res_ready;

    // --------------------
    // write strobe, count and done
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr  <= 1'b0;
            wr_count <= '0;
            done     <= 1'b0;
        end else begin
            if (load) begin
                grad_wr <= 1'b1;
            end else if (accept) begin
                grad_wr <= 1'b0;
            end

            if (accept) begin
                wr_count <= wr_count + 1'b1;
            end

            // sticky until the next reset
            if (wr_count == OUT_COUNT) begin
                done <= 1'b1;
            end
        end
    end

    // held word, stays put on the port while grad_wait is high
    always_ff @(posedge clk) begin
        if (load) begin
            grad_addr <= res_addr;
            grad_do   <= res_data;
        end
    end

endmodule

//--- grad_engine.sv
`timescale 1ns/1ps

module grad_engine
    import ig_geom_pkg::*;
    import ig_flow_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       pix_valid,
    input  pixel_t     pix_data,
    input  logic       res_ready,
    output logic       pix_pop,
    output logic       res_valid,
    output grad_word_t res_data,
    output pix_addr_t  res_addr
);

    // previous row, overwritten pixel by pixel as the new row streams in
    pixel_t line_buf [IMG_W];

    // position of the incoming pixel
    coord_t col;
    coord_t row;
    coord_t col_next;

    pixel_t     above;
    pixel_t     above_right;
    grad_comp_t gx;
    grad_comp_t gy;
    logic       last_col;
    logic       emit;

    // --------------------
    // handshake
    // --------------------

    // take a pixel only when the output register is free or is draining now
    assign pix_pop = pix_valid && (!res_valid || res_ready);

    assign col_next = col + 1'b1;
    assign last_col = (col == coord_t'(IMG_W - 1));

    // row 0 and column 255 only refill the line buffer
    assign emit = pix_pop && (row != '0) && !last_col;

    // --------------------
    // difference stage
    // --------------------

    // buf[x+1] still holds row y since it is overwritten later in the row
    assign above       = line_buf[col];
    assign above_right = line_buf[col_next];

    // zero-extend to 10 bits before subtracting so the sign survives
    assign gx = grad_comp_t'({2'b00, above_right}) - grad_comp_t'({2'b00, above});
    assign gy = grad_comp_t'({2'b00, pix_data}) - grad_comp_t'({2'b00, above});

    // --------------------
    // position counters and result valid
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            col       <= '0;
            row       <= '0;
            res_valid <= 1'b0;
        end else begin
            if (pix_pop) begin
                col <= col_next;
                if (last_col) begin
                    row <= row + 1'b1;
                end
            end

            if (emit) begin
                res_valid <= 1'b1;
            end else if (res_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    // line buffer refill
    always_ff @(posedge clk) begin
        if (pix_pop) begin
            line_buf[col] <= pix_data;
        end
    end

    // result register
    // result belongs to the row above the incoming pixel
    always_ff @(posedge clk) begin
        if (emit) begin
            res_data <= {gx, gy};
            res_addr <= {coord_t'(row - 1'b1), col};
        end
    end

endmodule

//--- pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo
    import ig_geom_pkg::*;
    import ig_flow_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   img_rd,
    input  pixel_t img_di,
    input  logic   pix_pop,
    output logic   pix_valid,
    output pixel_t pix_data,
    output logic   credit_return
);

    pixel_t    fifo_mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    credit_t   count;
    logic      push;
    logic      pop;

    assign pix_valid = (count != '0);
    assign pix_data  = fifo_mem[rd_ptr];
    assign pop       = pix_pop && pix_valid;

    // --------------------
    // pointers and occupancy
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            push          <= 1'b0;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            // image memory answers one cycle after the read strobe
            push          <= img_rd;
            credit_return <= pop;

            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    // credits keep the writer from ever running into a full FIFO
    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= img_di;
        end
    end

endmodule

//--- pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch
    import ig_geom_pkg::*;
    import ig_flow_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      credit_return,
    output logic      img_rd,
    output pix_addr_t img_addr
);

    credit_t credits;
    credit_t credits_avail;
    logic    fetch_done;
    logic    last_rd;
    logic    issue;

    // a credit handed back this cycle can be spent right away
    assign credits_avail = credits + credit_t'(credit_return);

    // final pixel of the image is being read in this cycle
    assign last_rd = img_rd && (img_addr == pix_addr_t'(PIX_COUNT - 1));

    assign issue = (credits_avail != '0) && !fetch_done && !last_rd;

    // --------------------
    // read strobe, address and credit count
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            credits    <= credit_t'(FIFO_DEPTH);
            fetch_done <= 1'b0;
            img_rd     <= 1'b0;
            img_addr   <= '0;
        end else begin
            // spend and return can happen in the same cycle
            credits <= credits_avail - credit_t'(issue);
            img_rd  <= issue;

            // step to the next raster position once a read has gone out
            if (img_rd) begin
                img_addr <= img_addr + 1'b1;
            end

            if (last_rd) begin
                fetch_done <= 1'b1;
            end
        end
    end

endmodule

//--- ig_flow_pkg.sv
package ig_flow_pkg;

    // --------------------
    // gradient word layout
    // --------------------
    localparam int GRAD_W = 10;

    // signed difference of two pixels, -255..255
    typedef logic signed [GRAD_W-1:0] grad_comp_t;

    // gx in the upper half, gy in the lower half
    typedef logic [2*GRAD_W-1:0] grad_word_t;

    // --------------------
    // pixel FIFO and credit sizing
    // --------------------
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    typedef logic [FIFO_AW-1:0] fifo_ptr_t;

    // holds 0..FIFO_DEPTH, also used for FIFO occupancy
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] credit_t;

endpackage

//--- ig_geom_pkg.sv
package ig_geom_pkg;

    // --------------------
    // image geometry, fixed by the external memories
    // --------------------
    localparam int IMG_W = 256;
    localparam int IMG_H = 256;

    // one read per pixel
    localparam int PIX_COUNT = IMG_W * IMG_H;

    // last column and last row have no forward neighbour
    localparam int OUT_COUNT = (IMG_W - 1) * (IMG_H - 1);

    // --------------------
    // pixel and address types
    // --------------------
    typedef logic [7:0] pixel_t;

    // linear address y*256+x, same layout in both memories
    typedef logic [15:0] pix_addr_t;

    // column or row index
    typedef logic [7:0] coord_t;

endpackage
